/* hw/rob_pkg.sv */
package rob_pkg;

	localparam int XLEN = 32;
	localparam int ROB_DEPTH_DEF = 8;

	typedef logic [2:0] rob_tag_t;

	// instruction as handed over by dispatch
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [4:0]      rd;
		logic            is_br;
		logic            br_pred;
		logic [XLEN-2:0] br_target;
	} rob_disp_t;

	typedef struct packed {
		logic            br_pred;
		logic [XLEN-2:0] br_target;
	} rob_br_t;

	// a branch keeps its prediction here, anything else its result
	typedef union packed {
		logic [XLEN-1:0] data;
		rob_br_t         br;
	} rob_val_u;

	// for branches data[0] is the taken bit
	typedef struct packed {
		rob_tag_t        tag;
		logic [XLEN-1:0] data;
	} rob_result_t;

	typedef struct packed {
		logic            valid;
		logic            done;
		logic [XLEN-1:0] pc;
		logic [4:0]      rd;
		logic            is_br;
		rob_val_u        val;
	} rob_entry_t;

	typedef struct packed {
		rob_tag_t        tag;
		logic [4:0]      rd;
		logic [XLEN-1:0] data;
	} rob_commit_t;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
	} rob_flush_t;

endpackage

/* hw/req_ack_rx.sv */
`timescale 1ns/1ps

module req_ack_rx #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     req_i,
	input  payload_t data_i,
	input  logic     take_i,
	output logic     ack_o,
	output logic     valid_o,
	output payload_t item_o
);

	logic ack_q;

	// the requester holds the payload stable while req is up
	assign item_o = data_i;

	// once taken, ack is up and hides the item until the channel
	// has gone back to idle
	assign valid_o = req_i & ~ack_q;
	assign ack_o   = ack_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
		end else if (take_i && valid_o) begin
			ack_q <= 1'b1;
		end else if (ack_q && !req_i) begin
			// requester has dropped req, close the four-phase cycle
			ack_q <= 1'b0;
		end
	end

endmodule

/* hw/rob_queue.sv */
`timescale 1ns/1ps

module rob_queue import rob_pkg::*; #(
	parameter int rob_depth = ROB_DEPTH_DEF
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            disp_valid_i,
	input  rob_disp_t       disp_i,
	input  logic            res_valid_i,
	input  rob_result_t     res_i,
	input  logic            flush_req_i,
	input  logic [XLEN-1:0] flush_pc_i,
	input  logic            pop_i,
	output logic            disp_take_o,
	output rob_tag_t        disp_tag_o,
	output rob_entry_t      res_entry_o,
	output rob_entry_t      head_o,
	output rob_tag_t        head_tag_o,
	output rob_flush_t      flush_o,
	output logic [3:0]      free_count_o
);

	localparam rob_tag_t ptr_mask = rob_tag_t'(rob_depth - 1);

	rob_entry_t      ents [rob_depth];
	rob_tag_t        head;
	rob_tag_t        tail;
	logic [3:0]      count;
	logic            flush_q;
	logic [XLEN-1:0] flush_pc_q;
	logic            res_live;
	rob_tag_t        br_dist;
	logic [3:0]      kept;

	function automatic rob_tag_t ptr_inc(rob_tag_t p);
		return (p + 3'd1) & ptr_mask;
	endfunction

	// position of a slot counted from the head in allocation order
	function automatic rob_tag_t age(rob_tag_t p, rob_tag_t h);
		return (p - h) & ptr_mask;
	endfunction

	// no allocation while a flush is being resolved or reported
	assign disp_take_o = disp_valid_i & (count != 4'(rob_depth)) & ~flush_req_i & ~flush_q;

	assign res_entry_o  = ents[res_i.tag];
	assign res_live     = res_valid_i & ents[res_i.tag].valid;
	assign head_o       = ents[head];
	assign head_tag_o   = head;
	assign flush_o      = '{valid: flush_q, pc: flush_pc_q};
	assign free_count_o = 4'(rob_depth) - count;

	// on a flush only head through the branch survive
	assign br_dist = age(res_i.tag, head);
	assign kept    = {1'b0, br_dist} + 4'd1 - {3'b0, pop_i};

	always_ff @(posedge clk) begin
		if (rst) begin
			head    <= '0;
			tail    <= '0;
			count   <= '0;
			flush_q <= 1'b0;
			for (int i = 0; i < rob_depth; i++) begin
				ents[i].valid <= 1'b0;
				ents[i].done  <= 1'b0;
			end
		end else begin
			flush_q <= flush_req_i;
			if (disp_take_o) begin
				ents[tail].valid  <= 1'b1;
				ents[tail].done   <= 1'b0;
				ents[tail].pc     <= disp_i.pc;
				ents[tail].rd     <= disp_i.rd;
				ents[tail].is_br  <= disp_i.is_br;
				ents[tail].val.br <= '{br_pred: disp_i.br_pred, br_target: disp_i.br_target};
				disp_tag_o        <= tail;
				tail              <= ptr_inc(tail);
			end
			// late results for freed slots fall through here
			if (res_live) begin
				ents[res_i.tag].done <= 1'b1;
				if (!ents[res_i.tag].is_br) begin
					ents[res_i.tag].val.data <= res_i.data;
				end
			end
			if (pop_i) begin
				ents[head].valid <= 1'b0;
				head             <= ptr_inc(head);
			end
			if (flush_req_i) begin
				for (int i = 0; i < rob_depth; i++) begin
					if (age(rob_tag_t'(i), head) > br_dist) begin
						ents[i].valid <= 1'b0;
					end
				end
				tail  <= ptr_inc(res_i.tag);
				count <= kept;
			end else begin
				count <= count + {3'b0, disp_take_o} - {3'b0, pop_i};
			end
		end
	end

	always_ff @(posedge clk) begin
		flush_pc_q <= flush_pc_i;
	end

endmodule

/* hw/rob_branch_check.sv */
`timescale 1ns/1ps

module rob_branch_check import rob_pkg::*; (
	input  logic            res_valid_i,
	input  rob_result_t     res_i,
	input  rob_entry_t      res_entry_i,
	output logic            flush_req_o,
	output logic [XLEN-1:0] flush_pc_o
);

	logic            br_live;
	logic            taken;
	logic            mispredict;
	logic [XLEN-1:0] target_pc;
	logic [XLEN-1:0] fall_pc;

	// only a live branch entry can redirect
	assign br_live = res_valid_i & res_entry_i.valid & res_entry_i.is_br;

	assign taken      = res_i.data[0];
	assign mispredict = taken != res_entry_i.val.br.br_pred;

	// target is stored without its low bit
	assign target_pc = {res_entry_i.val.br.br_target, 1'b0};
	assign fall_pc   = res_entry_i.pc + XLEN'(4);

	assign flush_req_o = br_live & mispredict;
	assign flush_pc_o  = taken ? target_pc : fall_pc;

endmodule

/* hw/rob_commit.sv */
`timescale 1ns/1ps

module rob_commit import rob_pkg::*; #(
	parameter int rob_depth = ROB_DEPTH_DEF
) (
	input  logic        clk,
	input  logic        rst,
	input  rob_entry_t  head_i,
	input  rob_tag_t    head_tag_i,
	input  logic        commit_ack_i,
	output logic        pop_o,
	output logic        commit_req_o,
	output rob_commit_t commit_o
);

	localparam rob_tag_t tag_mask = rob_tag_t'(rob_depth - 1);

	typedef enum logic [1:0] {
		st_idle,
		st_req,
		st_ack_low
	} state_t;

	state_t state;
	state_t state_nx;
	logic   head_ready;

	assign head_ready   = head_i.valid & head_i.done;
	assign commit_req_o = (state == st_req);

	always_comb begin
		state_nx = state;
		pop_o    = 1'b0;
		case (state)
			st_idle: begin
				if (head_ready && head_i.is_br) begin
					// branches leave without a register file write
					pop_o = 1'b1;
				end else if (head_ready) begin
					state_nx = st_req;
				end
			end
			st_req: begin
				if (commit_ack_i) begin
					pop_o    = 1'b1;
					state_nx = st_ack_low;
				end
			end
			st_ack_low: begin
				if (!commit_ack_i) begin
					state_nx = st_idle;
				end
			end
			default: begin
				state_nx = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= state_nx;
		end
	end

	// held stable for the whole request
	always_ff @(posedge clk) begin
		if (state == st_idle && head_ready && !head_i.is_br) begin
			commit_o <= '{tag: head_tag_i & tag_mask, rd: head_i.rd, data: head_i.val.data};
		end
	end

endmodule

/* hw/rob_top.sv */
`timescale 1ns/1ps

module rob_top import rob_pkg::*; #(
	parameter int rob_depth = ROB_DEPTH_DEF
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        disp_req_i,
	input  rob_disp_t   disp_i,
	input  logic        res_req_i,
	input  rob_result_t res_i,
	input  logic        commit_ack_i,
	output logic        disp_ack_o,
	output rob_tag_t    disp_tag_o,
	output logic        res_ack_o,
	output logic        commit_req_o,
	output rob_commit_t commit_o,
	output rob_flush_t  flush_o,
	output logic [3:0]  free_count_o
);

	logic            disp_valid;
	rob_disp_t       disp_item;
	logic            disp_take;
	logic            res_valid;
	rob_result_t     res_item;
	rob_entry_t      res_entry;
	rob_entry_t      head;
	rob_tag_t        head_tag;
	logic            pop;
	logic            flush_req;
	logic [XLEN-1:0] flush_pc;

	req_ack_rx #(.payload_t(rob_disp_t)) u_disp_rx (
		.clk(clk), .rst(rst), .req_i(disp_req_i), .data_i(disp_i), .take_i(disp_take),
		.ack_o(disp_ack_o), .valid_o(disp_valid), .item_o(disp_item)
	);

	// results are always accepted on sight
	req_ack_rx #(.payload_t(rob_result_t)) u_res_rx (
		.clk(clk), .rst(rst), .req_i(res_req_i), .data_i(res_i), .take_i(res_valid),
		.ack_o(res_ack_o), .valid_o(res_valid), .item_o(res_item)
	);

	rob_queue #(.rob_depth(rob_depth)) u_queue (
		.clk(clk), .rst(rst),
		.disp_valid_i(disp_valid), .disp_i(disp_item),
		.res_valid_i(res_valid), .res_i(res_item),
		.flush_req_i(flush_req), .flush_pc_i(flush_pc), .pop_i(pop),
		.disp_take_o(disp_take), .disp_tag_o(disp_tag_o), .res_entry_o(res_entry),
		.head_o(head), .head_tag_o(head_tag), .flush_o(flush_o), .free_count_o(free_count_o)
	);

	rob_branch_check u_br_check (
		.res_valid_i(res_valid), .res_i(res_item), .res_entry_i(res_entry),
		.flush_req_o(flush_req), .flush_pc_o(flush_pc)
	);

	rob_commit #(.rob_depth(rob_depth)) u_commit (
		.clk(clk), .rst(rst), .head_i(head), .head_tag_i(head_tag),
		.commit_ack_i(commit_ack_i), .pop_o(pop),
		.commit_req_o(commit_req_o), .commit_o(commit_o)
	);

endmodule

/* dv/rob_tb.sv */
`timescale 1ns/1ps

module rob_tb import rob_pkg::*; ();

	localparam int TMO = 200;
	localparam int OP_DISP = 0;
	localparam int OP_RES = 1;
	localparam int OP_DRAIN = 2;
	localparam int OP_HOLD = 3;
	localparam int OP_FULL_DISP = 4;

	typedef struct {
		string       name;
		int          op;
		rob_disp_t   d;
		rob_result_t r;
		rob_tag_t    exp_tag;
	} row_t;

	logic        clk;
	logic        rst;
	logic        disp_req_i;
	rob_disp_t   disp_i;
	logic        res_req_i;
	rob_result_t res_i;
	logic        commit_ack_i;
	logic        disp_ack_o;
	rob_tag_t    disp_tag_o;
	logic        res_ack_o;
	logic        commit_req_o;
	rob_commit_t commit_o;
	rob_flush_t  flush_o;
	logic [3:0]  free_count_o;

	row_t        rows[$];
	int          errors;
	int          rows_failed;
	bit          hold_ack;
	logic [39:0] exp_q[$];
	logic [39:0] got_q[$];
	int          flush_cnt;
	int          exp_flush_cnt;
	logic [31:0] flush_pc_seen;
	logic [31:0] exp_flush_pc;

	// reference model of the entry queue
	bit          m_valid[8];
	bit          m_done[8];
	bit          m_br[8];
	bit          m_pred[8];
	logic [31:0] m_pc[8];
	logic [31:0] m_data[8];
	logic [30:0] m_tgt[8];
	logic [4:0]  m_rd[8];
	rob_tag_t    m_head;
	rob_tag_t    m_tail;

	rob_top #(.rob_depth(8)) uut (
		.clk(clk), .rst(rst), .disp_req_i(disp_req_i), .disp_i(disp_i),
		.res_req_i(res_req_i), .res_i(res_i), .commit_ack_i(commit_ack_i),
		.disp_ack_o(disp_ack_o), .disp_tag_o(disp_tag_o), .res_ack_o(res_ack_o),
		.commit_req_o(commit_req_o), .commit_o(commit_o), .flush_o(flush_o),
		.free_count_o(free_count_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		#2_000_000;
		$display("simulation did not finish in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("Error %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic wait_level(input string name, input string sig, input bit level);
		int n;
		logic v;
		n = 0;
		@(negedge clk);
		v = (sig == "disp") ? disp_ack_o : res_ack_o;
		while (v != level && n < TMO) begin
			@(negedge clk);
			v = (sig == "disp") ? disp_ack_o : res_ack_o;
			n++;
		end
		if (v != level) begin
			$display("%s: %s ack did not reach %0d in time", name, sig, level);
			errors++;
		end
	endtask

	task automatic model_res(input rob_result_t r);
		rob_tag_t t;
		rob_tag_t p;
		t = r.tag;
		if (m_valid[t]) begin
			m_done[t] = 1'b1;
			m_data[t] = r.data;
			if (m_br[t] && r.data[0] != m_pred[t]) begin
				exp_flush_cnt++;
				exp_flush_pc = r.data[0] ? {m_tgt[t], 1'b0} : m_pc[t] + 32'd4;
				p = t + 3'd1;
				while (p != m_tail) begin
					m_valid[p] = 1'b0;
					p = p + 3'd1;
				end
				m_tail = t + 3'd1;
			end
		end
		while (m_valid[m_head] && m_done[m_head]) begin
			if (!m_br[m_head]) begin
				exp_q.push_back({m_head, m_rd[m_head], m_data[m_head]});
			end
			m_valid[m_head] = 1'b0;
			m_head = m_head + 3'd1;
		end
	endtask

	task automatic run_disp(input row_t row, input bit full);
		@(posedge clk);
		disp_req_i <= 1'b1;
		disp_i     <= row.d;
		if (full) begin
			repeat (10) begin
				@(negedge clk);
				if (disp_ack_o) begin
					$display("%s: dispatch acknowledged while the queue is full", row.name);
					errors++;
				end
			end
			hold_ack = 1'b0;
		end
		wait_level(row.name, "disp", 1'b1);
		check(row.name, row.exp_tag, disp_tag_o);
		@(posedge clk);
		disp_req_i <= 1'b0;
		wait_level(row.name, "disp", 1'b0);
		m_valid[m_tail] = 1'b1;
		m_done[m_tail]  = 1'b0;
		m_br[m_tail]    = row.d.is_br;
		m_pred[m_tail]  = row.d.br_pred;
		m_pc[m_tail]    = row.d.pc;
		m_tgt[m_tail]   = row.d.br_target;
		m_rd[m_tail]    = row.d.rd;
		m_tail          = m_tail + 3'd1;
	endtask

	task automatic run_res(input row_t row);
		@(posedge clk);
		res_req_i <= 1'b1;
		res_i     <= row.r;
		wait_level(row.name, "res", 1'b1);
		@(posedge clk);
		res_req_i <= 1'b0;
		wait_level(row.name, "res", 1'b0);
		model_res(row.r);
		// a commit may not run ahead of the model
		if (got_q.size() > exp_q.size()) begin
			$display("%s: commit seen before its entry could retire", row.name);
			errors++;
		end
	endtask

	task automatic drain(input string name);
		int n;
		n = 0;
		while (got_q.size() < exp_q.size() && n < TMO) begin
			@(negedge clk);
			n++;
		end
		repeat (4) @(negedge clk);
		if (got_q.size() != exp_q.size()) begin
			$display("%s: expected %0d commits, saw %0d", name, exp_q.size(), got_q.size());
			errors++;
		end
		for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
			check(name, exp_q[i], got_q[i]);
		end
		check(name, exp_flush_cnt, flush_cnt);
		if (exp_flush_cnt > 0) begin
			check(name, exp_flush_pc, flush_pc_seen);
		end
		exp_q.delete();
		got_q.delete();
	endtask

	task automatic add(input string n, input int op, input rob_disp_t d,
			input rob_result_t r, input rob_tag_t t);
		rows.push_back('{name: n, op: op, d: d, r: r, exp_tag: t});
	endtask

	function automatic rob_disp_t alu(input logic [31:0] pc, input logic [4:0] rd);
		return '{pc: pc, rd: rd, is_br: 1'b0, br_pred: 1'b0, br_target: '0};
	endfunction

	function automatic rob_disp_t br(input logic [31:0] pc, input bit pred,
			input logic [30:0] tgt);
		return '{pc: pc, rd: 5'd0, is_br: 1'b1, br_pred: pred, br_target: tgt};
	endfunction

	function automatic rob_result_t res(input int tag, input logic [31:0] data);
		return '{tag: rob_tag_t'(tag), data: data};
	endfunction

	task automatic build_table();
		for (int k = 0; k < 4; k++) begin
			add($sformatf("order_disp_%0d", k), OP_DISP, alu(32'h40 + k * 4, 5'(k + 1)),
				'0, rob_tag_t'(k));
		end
		for (int k = 3; k >= 0; k--) begin
			add($sformatf("order_res_%0d", k), OP_RES, '0, res(k, 32'hA000 + k), '0);
		end
		add("order_drain", OP_DRAIN, '0, '0, '0);
		add("br_ok_disp_br", OP_DISP, br(32'h80, 1'b1, 31'h0123), '0, 3'd4);
		add("br_ok_disp_alu", OP_DISP, alu(32'h84, 5'd7), '0, 3'd5);
		add("br_ok_res_alu", OP_RES, '0, res(5, 32'hB005), '0);
		add("br_ok_res_br", OP_RES, '0, res(4, 32'h1), '0);
		add("br_ok_drain", OP_DRAIN, '0, '0, '0);
		add("mis_disp_br", OP_DISP, br(32'h100, 1'b0, 31'h0200), '0, 3'd6);
		add("mis_disp_young0", OP_DISP, alu(32'h104, 5'd8), '0, 3'd7);
		add("mis_disp_young1", OP_DISP, alu(32'h108, 5'd9), '0, 3'd0);
		add("mis_res_br", OP_RES, '0, res(6, 32'h1), '0);
		add("mis_res_dead0", OP_RES, '0, res(7, 32'hDEAD), '0);
		add("mis_res_dead1", OP_RES, '0, res(0, 32'hBEEF), '0);
		add("mis_disp_reuse", OP_DISP, alu(32'h400, 5'd10), '0, 3'd7);
		add("mis_res_reuse", OP_RES, '0, res(7, 32'hC007), '0);
		add("mis_drain", OP_DRAIN, '0, '0, '0);
		add("nt_disp_br", OP_DISP, br(32'h200, 1'b1, 31'h0700), '0, 3'd0);
		add("nt_disp_young", OP_DISP, alu(32'h204, 5'd11), '0, 3'd1);
		add("nt_res_br", OP_RES, '0, res(0, 32'h0), '0);
		add("nt_res_dead", OP_RES, '0, res(1, 32'hDEAD), '0);
		add("nt_disp_reuse", OP_DISP, alu(32'h204, 5'd12), '0, 3'd1);
		add("nt_res_reuse", OP_RES, '0, res(1, 32'hD001), '0);
		add("nt_drain", OP_DRAIN, '0, '0, '0);
		add("full_hold", OP_HOLD, '0, '0, '0);
		for (int k = 0; k < 8; k++) begin
			add($sformatf("full_disp_%0d", k), OP_DISP, alu(32'h1000 + k * 4, 5'(13 + k)),
				'0, rob_tag_t'(2 + k));
		end
		add("full_res_head", OP_RES, '0, res(2, 32'hE002), '0);
		add("full_disp_ninth", OP_FULL_DISP, alu(32'h1020, 5'd21), '0, 3'd2);
		for (int k = 3; k < 11; k++) begin
			add($sformatf("full_res_%0d", k), OP_RES, '0, res(k % 8, 32'hF000 + k), '0);
		end
		add("full_drain", OP_DRAIN, '0, '0, '0);
	endtask

	// register file side of the commit handshake
	initial begin
		int n;
		void'($urandom(32'hc673));
		forever begin
			@(negedge clk);
			if (commit_req_o && !hold_ack && !commit_ack_i) begin
				got_q.push_back(commit_o);
				repeat ($urandom % 4) @(posedge clk);
				@(posedge clk);
				commit_ack_i <= 1'b1;
				n = 0;
				@(negedge clk);
				while (commit_req_o && n < TMO) begin
					@(negedge clk);
					n++;
				end
				if (commit_req_o) begin
					$display("commit request stayed high after ack");
					errors++;
				end
				@(posedge clk);
				commit_ack_i <= 1'b0;
			end
		end
	end

	always @(negedge clk) begin
		if (!rst && flush_o.valid) begin
			flush_cnt++;
			flush_pc_seen = flush_o.pc;
		end
	end

	initial begin
		int err0;
		rst          = 1'b1;
		disp_req_i   = 1'b0;
		disp_i       = '0;
		res_req_i    = 1'b0;
		res_i        = '0;
		commit_ack_i = 1'b0;
		hold_ack     = 1'b0;
		errors       = 0;
		rows_failed  = 0;
		m_head       = '0;
		m_tail       = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check("reset_disp_ack", 0, disp_ack_o);
		check("reset_res_ack", 0, res_ack_o);
		check("reset_commit_req", 0, commit_req_o);
		check("reset_flush", 0, flush_o.valid);
		check("reset_free_count", 8, free_count_o);
		$display("reset: %s", errors == 0 ? "ok" : "FAILED");
		if (errors != 0) begin
			rows_failed++;
		end
		build_table();
		foreach (rows[i]) begin
			err0 = errors;
			case (rows[i].op)
				OP_DISP: run_disp(rows[i], 1'b0);
				OP_FULL_DISP: run_disp(rows[i], 1'b1);
				OP_RES: run_res(rows[i]);
				OP_HOLD: hold_ack = 1'b1;
				default: drain(rows[i].name);
			endcase
			$display("%s: %s", rows[i].name, errors == err0 ? "ok" : "FAILED");
			if (errors != err0) begin
				rows_failed++;
			end
		end
		$display("tests %0d, failed %0d, errors %0d", rows.size() + 1, rows_failed, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* sources.f */
hw/rob_pkg.sv
hw/req_ack_rx.sv
hw/rob_queue.sv
hw/rob_branch_check.sv
hw/rob_commit.sv
hw/rob_top.sv
dv/rob_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the reorder buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module rob_tb -f sources.f -o rob_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/rob_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF "*** TEST FAILED ***" sim.log; then
	exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
	echo "no result line in sim.log"
	exit 1
fi
exit 0
